// ==== ssr_indir.f ====
+incdir+verif
source/ssr_indir_pkg.sv
source/ssr_idx_fetch.sv
source/ssr_idx_fifo.sv
source/ssr_idx_serializer.sv
source/ssr_indirector.sv
verif/tb_ssr_indirector.sv

// ==== Bender.yml ====
package:
  name: ssr_indir

sources:
  - source/ssr_indir_pkg.sv
  - source/ssr_idx_fetch.sv
  - source/ssr_idx_fifo.sv
  - source/ssr_idx_serializer.sv
  - source/ssr_indirector.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_ssr_indirector.sv

// ==== verif/ssr_indir_model.svh ====
/*
  Reference model for the indirection stage testbench
  Random index memory, response latency queue and expected
  pointer, last flag, word pop and word address lists per job
*/

`ifndef SSR_INDIR_MODEL_SVH
`define SSR_INDIR_MODEL_SVH

localparam int unsigned MEM_WORDS = 256;

// Index memory, one entry per aligned word
data_t  mem_words [MEM_WORDS];

// Expected pointer stream, one entry per index
addr_t  exp_ptr_q [$];
logic   exp_last_q [$];
// High where the index is the last one taken from its word
logic   exp_pop_q [$];

// Word addresses the fetch walk must request, in order
addr_t  exp_addr_q [$];

// Responses in flight, data and the cycle they are due
data_t  rsp_data_q [$];
int     rsp_due_q [$];

function automatic void fill_memory();
  for (int i = 0; i < MEM_WORDS; i++) begin
    mem_words[i] = $urandom();
  end
endfunction

function automatic data_t read_word(addr_t addr);
  return mem_words[(addr >> 2) % MEM_WORDS];
endfunction

// Little-endian index of 1, 2 or 4 bytes at a byte address
function automatic index_t read_index(addr_t addr, idx_size_t size);
  index_t v;
  data_t  w;
  addr_t  b;
  v = '0;
  for (int j = 0; j < (1 << size); j++) begin
    b = addr + addr_t'(j);
    w = read_word(b);
    v[8*j +: 8] = w[8*b[1:0] +: 8];
  end
  return v;
endfunction

function automatic void build_job(indir_cfg_t cfg);
  int unsigned nbytes;
  addr_t       a;
  addr_t       w_addr;
  addr_t       last_w;
  index_t      idx;
  nbytes = 1 << cfg.size;
  for (int k = 0; k < int'(cfg.idx_count); k++) begin
    a   = cfg.idx_addr + addr_t'(k * nbytes);
    idx = read_index(a, cfg.size);
    exp_ptr_q.push_back(cfg.data_base + ((idx << 2) << cfg.shift));
    exp_last_q.push_back(k == int'(cfg.idx_count) - 1);
    exp_pop_q.push_back(((a + nbytes) % 4 == 0) || (k == int'(cfg.idx_count) - 1));
  end
  // Every aligned word touched by the array, once each
  w_addr = cfg.idx_addr & ~addr_t'(3);
  last_w = (cfg.idx_addr + addr_t'(cfg.idx_count * nbytes) - 1) & ~addr_t'(3);
  while (w_addr <= last_w) begin
    exp_addr_q.push_back(w_addr);
    w_addr = w_addr + 4;
  end
endfunction

`endif

// ==== verif/tb_ssr_indirector.sv ====
/*
  Testbench for the indirection address stage
  Random jobs against a random memory with random grant, latency
  and output stalls, checked against the reference model
*/

`timescale 1ns/1ps

module tb_ssr_indirector import ssr_indir_pkg::*; ();

  localparam int unsigned NUM_JOBS   = 40;
  localparam int unsigned MAX_COUNT  = 32;
  // Per job about 8 cycles per index plus start and drain overhead
  localparam int unsigned MAX_CYCLES = NUM_JOBS * (MAX_COUNT * 8 + 100);

  logic       clk_i;
  logic       rst_i;
  logic       start_i;
  indir_cfg_t cfg_i;
  logic       busy_o;
  idx_req_t   idx_req_o;
  idx_rsp_t   idx_rsp_i;
  addr_t      mem_pointer_o;
  logic       mem_last_o;
  logic       mem_valid_o;
  logic       mem_ready_i;

  int         cyc;
  int         err_cnt;
  int         outstanding;
  int         last_due;
  // Output seen stalled on the previous falling edge
  logic       hold_valid;
  addr_t      hold_ptr;
  logic       hold_last;

  `include "ssr_indir_model.svh"

  ssr_indirector i_ssr_indirector (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .start_i       ( start_i       ),
    .cfg_i         ( cfg_i         ),
    .busy_o        ( busy_o        ),
    .idx_req_o     ( idx_req_o     ),
    .idx_rsp_i     ( idx_rsp_i     ),
    .mem_pointer_o ( mem_pointer_o ),
    .mem_last_o    ( mem_last_o    ),
    .mem_valid_o   ( mem_valid_o   ),
    .mem_ready_i   ( mem_ready_i   )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Check failed at cycle %0d: %s", cyc, what);
      err_cnt++;
    end
  endtask

  // Start offset aligned to the index size but not to the word
  function automatic indir_cfg_t make_cfg();
    indir_cfg_t  c;
    int unsigned offs;
    c.size      = idx_size_t'($urandom_range(0, 2));
    c.idx_count = count_t'($urandom_range(1, MAX_COUNT));
    offs        = ($urandom_range(0, 3) >> c.size) << c.size;
    c.idx_addr  = addr_t'($urandom_range(0, MEM_WORDS - 40)) * 4 + addr_t'(offs);
    c.data_base = $urandom();
    c.shift     = shift_t'($urandom_range(0, 7));
    return c;
  endfunction

  // Per falling edge check outputs and then drive memory side and ready
  task automatic step_cycle();
    logic rdy;
    logic req_hs;
    logic pop_now;
    int   due;
    cyc++;
    pop_now = 1'b0;
    if (hold_valid) begin
      check_value("mem_valid_o", 32'(mem_valid_o), 32'h1);
      check_value("mem_pointer_o", mem_pointer_o, hold_ptr);
      check_value("mem_last_o", 32'(mem_last_o), 32'(hold_last));
    end
    rdy         = ($urandom_range(0, 3) != 0);
    mem_ready_i = rdy;
    hold_valid  = mem_valid_o & ~rdy;
    hold_ptr    = mem_pointer_o;
    hold_last   = mem_last_o;
    // Pointer transfers on the coming rising edge
    if (mem_valid_o & rdy) begin
      if (exp_ptr_q.size() == 0) begin
        check_true(1'b0, "pointer emitted beyond the job's index count");
      end else begin
        check_value("mem_pointer_o", mem_pointer_o, exp_ptr_q.pop_front());
        check_value("mem_last_o", 32'(mem_last_o), 32'(exp_last_q.pop_front()));
        pop_now = exp_pop_q.pop_front();
      end
    end
    // Response due this cycle in request order
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
      void'(rsp_due_q.pop_front());
      idx_rsp_i.p_valid = 1'b1;
      idx_rsp_i.data    = rsp_data_q.pop_front();
    end else begin
      idx_rsp_i.p_valid = 1'b0;
      idx_rsp_i.data    = '0;
    end
    idx_rsp_i.q_ready = ($urandom_range(0, 3) != 0);
    req_hs = idx_req_o.valid & idx_rsp_i.q_ready;
    if (req_hs) begin
      if (exp_addr_q.size() == 0) begin
        check_true(1'b0, "word request beyond the end of the index array");
      end else begin
        check_value("idx_req_o.addr", idx_req_o.addr, exp_addr_q.pop_front());
      end
      outstanding++;
      check_true(outstanding <= IDX_CREDITS, "more words outstanding than credits");
      // Latency of 1 to 6 cycles without overtaking an earlier response
      due = cyc + $urandom_range(1, 6);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_due_q.push_back(due);
      rsp_data_q.push_back(read_word(idx_req_o.addr));
    end
    if (pop_now) begin
      outstanding--;
    end
  endtask

  // Cycle counter that ends a hung run
  initial begin
    int unsigned n;
    n = 0;
    while (n < MAX_CYCLES) begin
      @(posedge clk_i);
      n++;
    end
    $display("Run stopped after %0d cycles without finishing all jobs", n);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    indir_cfg_t cfg;
    int         errs_before;
    void'($urandom(89871));
    rst_i       = 1'b1;
    start_i     = 1'b0;
    cfg_i       = '0;
    idx_rsp_i   = '0;
    mem_ready_i = 1'b0;
    cyc         = 0;
    err_cnt     = 0;
    outstanding = 0;
    last_due    = 0;
    hold_valid  = 1'b0;
    fill_memory();
    repeat (8) @(negedge clk_i);
    check_value("idx_req_o.valid", 32'(idx_req_o.valid), 32'h0);
    check_value("mem_valid_o", 32'(mem_valid_o), 32'h0);
    check_value("busy_o", 32'(busy_o), 32'h0);
    rst_i = 1'b0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      errs_before = err_cnt;
      cfg = make_cfg();
      build_job(cfg);
      @(negedge clk_i);
      step_cycle();
      check_value("busy_o", 32'(busy_o), 32'h0);
      start_i = 1'b1;
      cfg_i   = cfg;
      @(negedge clk_i);
      step_cycle();
      check_value("busy_o", 32'(busy_o), 32'h1);
      // Second start while busy must leave the job untouched
      cfg_i = make_cfg();
      @(negedge clk_i);
      step_cycle();
      start_i = 1'b0;
      while (exp_ptr_q.size() != 0) begin
        @(negedge clk_i);
        step_cycle();
      end
      @(negedge clk_i);
      step_cycle();
      check_value("busy_o", 32'(busy_o), 32'h0);
      check_true(exp_addr_q.size() == 0, "not every word of the index array was requested");
      $display("job %0d size %0d count %0d shift %0d: %s", j, cfg.size, cfg.idx_count,
               cfg.shift, (err_cnt == errs_before) ? "ok" : "errors");
    end
    $display("jobs run %0d, errors %0d", NUM_JOBS, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== source/ssr_indirector.sv ====
/*
  Indirection address stage top
  Job register and busy flag around fetch, index FIFO and serializer
*/

`timescale 1ns/1ps

module ssr_indirector import ssr_indir_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Job start
  input  logic       start_i,
  input  indir_cfg_t cfg_i,
  output logic       busy_o,
  // Index memory port
  output idx_req_t   idx_req_o,
  input  idx_rsp_t   idx_rsp_i,
  // Pointer stream
  output addr_t      mem_pointer_o,
  output logic       mem_last_o,
  output logic       mem_valid_o,
  input  logic       mem_ready_i
);

  // Job state
  indir_cfg_t cfg_q;
  logic       busy_q;
  logic       job_start_q;
  logic       start_acc;

  // Fetch to FIFO
  logic       push;
  data_t      push_data;

  // FIFO to serializer
  idx_word_u  head_word;
  logic       fifo_empty;
  logic       fifo_pop;

  logic       job_done;

  // Starts while busy are dropped
  assign start_acc = start_i & ~busy_q;
  assign busy_o    = busy_q;

  always_ff @(posedge clk_i) begin
    if (start_acc) begin
      cfg_q <= cfg_i;
    end
  end

  // Busy from the cycle after acceptance until after the last pointer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      job_start_q <= 1'b0;
    end else begin
      job_start_q <= start_acc;
      if (start_acc) begin
        busy_q <= 1'b1;
      end else if (job_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  ssr_idx_fetch i_fetch (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .job_start_i   ( job_start_q ),
    .cfg_i         ( cfg_q       ),
    .idx_req_o     ( idx_req_o   ),
    .idx_rsp_i     ( idx_rsp_i   ),
    .credit_give_i ( fifo_pop    ),
    .push_o        ( push        ),
    .push_data_o   ( push_data   )
  );

  ssr_idx_fifo i_fifo (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .push_i  ( push       ),
    .data_i  ( push_data  ),
    .pop_i   ( fifo_pop   ),
    .data_o  ( head_word  ),
    .empty_o ( fifo_empty )
  );

  ssr_idx_serializer i_serializer (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .job_start_i   ( job_start_q   ),
    .cfg_i         ( cfg_q         ),
    .word_i        ( head_word     ),
    .empty_i       ( fifo_empty    ),
    .pop_o         ( fifo_pop      ),
    .mem_pointer_o ( mem_pointer_o ),
    .mem_last_o    ( mem_last_o    ),
    .mem_valid_o   ( mem_valid_o   ),
    .mem_ready_i   ( mem_ready_i   ),
    .done_o        ( job_done      )
  );

endmodule

// ==== source/ssr_idx_serializer.sv ====
/*
  Index serializer and pointer generation
  Cuts FIFO head words into indices of the configured size, tracks the
  last index of the job and emits base + (index << 2 << shift)
*/

`timescale 1ns/1ps

module ssr_idx_serializer import ssr_indir_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       job_start_i,
  input  indir_cfg_t cfg_i,
  // FIFO head
  input  idx_word_u  word_i,
  input  logic       empty_i,
  output logic       pop_o,
  // Pointer output
  output addr_t      mem_pointer_o,
  output logic       mem_last_o,
  output logic       mem_valid_o,
  input  logic       mem_ready_i,
  // Final handshake of the job
  output logic       done_o
);

  // Byte position of the current index in the head word
  bytecnt_t bytecnt_q;
  bytecnt_t bytecnt_next;
  logic     bytecnt_rovr;

  // Indices still to emit
  count_t   idx_left_q;
  logic     idx_is_last;

  // Output handshake
  logic     mem_hs;

  // Selected index, zero extended
  index_t   idx_sel;
  addr_t    idx_scaled;

  assign mem_valid_o = ~empty_i;
  assign mem_hs      = mem_valid_o & mem_ready_i;

  // Step by index size in bytes, wraps at word boundary
  assign bytecnt_next = bytecnt_q + bytecnt_t'(1 << cfg_i.size);
  assign bytecnt_rovr = (bytecnt_next == '0);

  assign idx_is_last  = (idx_left_q == count_t'(1));

  // Byte counter, preset with the array's start offset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bytecnt_q <= '0;
    end else if (job_start_i) begin
      bytecnt_q <= cfg_i.idx_addr[BYTECNT_WIDTH-1:0];
    end else if (mem_hs) begin
      bytecnt_q <= bytecnt_next;
    end
  end

  // Remaining index count
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      idx_left_q <= '0;
    end else if (job_start_i) begin
      idx_left_q <= cfg_i.idx_count;
    end else if (mem_hs) begin
      idx_left_q <= idx_left_q - 1'b1;
    end
  end

  // Pick the view that matches the index size
  always_comb begin
    case (cfg_i.size)
      2'd0:    idx_sel = index_t'(word_i.bytes[bytecnt_q]);
      2'd1:    idx_sel = index_t'(word_i.halves[bytecnt_q[1]]);
      default: idx_sel = index_t'(word_i.word);
    endcase
  end

  // Word pointer from index, then extra element shift
  assign idx_scaled    = (addr_t'(idx_sel) << BYTECNT_WIDTH) << cfg_i.shift;
  assign mem_pointer_o = cfg_i.data_base + idx_scaled;

  // All inputs to pointer and flag hold while stalled
  assign mem_last_o    = idx_is_last;

  // Release head word when its top index or the job's last index is taken
  assign pop_o  = mem_hs & (bytecnt_rovr | idx_is_last);

  // Job ends with the handshake of the last pointer
  assign done_o = mem_hs & idx_is_last;

endmodule

// ==== source/ssr_idx_fifo.sv ====
/*
  Index word FIFO
  Registered storage of IDX_CREDITS words with wrap-bit pointers
  Overflow is ruled out upstream by the credit counter
*/

`timescale 1ns/1ps

module ssr_idx_fifo import ssr_indir_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      push_i,
  input  data_t     data_i,
  input  logic      pop_i,
  output idx_word_u data_o,
  output logic      empty_o
);

  // Word storage
  data_t mem_q [IDX_CREDITS];

  // Read and write pointers with an extra wrap bit
  logic [FIFO_AWIDTH:0] wr_ptr_q;
  logic [FIFO_AWIDTH:0] rd_ptr_q;

  logic [FIFO_AWIDTH-1:0] wr_idx;
  logic [FIFO_AWIDTH-1:0] rd_idx;

  assign wr_idx = wr_ptr_q[FIFO_AWIDTH-1:0];
  assign rd_idx = rd_ptr_q[FIFO_AWIDTH-1:0];

  // Equal pointers including wrap bit means nothing stored
  assign empty_o = (wr_ptr_q == rd_ptr_q);

  // Head word becomes visible the cycle after its push
  assign data_o = idx_word_u'(mem_q[rd_idx]);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_idx] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (push_i) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // Pop only ever comes with a valid head
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (pop_i & ~empty_o) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

endmodule

// ==== source/ssr_idx_fetch.sv ====
/*
  Index word fetch
  Walks the aligned words spanned by the index array, issues one read per
  cycle while credits remain and forwards responses to the FIFO
*/

`timescale 1ns/1ps

module ssr_idx_fetch import ssr_indir_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       job_start_i,
  input  indir_cfg_t cfg_i,
  output idx_req_t   idx_req_o,
  input  idx_rsp_t   idx_rsp_i,
  input  logic       credit_give_i,
  output logic       push_o,
  output data_t      push_data_o
);

  // Array extent in bytes from the aligned start, rounded up to whole words
  logic [COUNT_WIDTH+2:0] span_bytes;
  logic [COUNT_WIDTH:0]   span_words;

  // Walk state
  logic [COUNT_WIDTH:0]   words_left_q;
  addr_t                  word_addr_q;

  // Credits
  logic [CREDIT_WIDTH-1:0] credits_q;
  logic                    cred_left;
  logic                    req_hs;

  // Offset of first index plus array bytes plus 3 for round up
  assign span_bytes = ((COUNT_WIDTH+3)'(cfg_i.idx_count) << cfg_i.size)
                    + (COUNT_WIDTH+3)'(cfg_i.idx_addr[BYTECNT_WIDTH-1:0])
                    + (COUNT_WIDTH+3)'(3);
  assign span_words = span_bytes[COUNT_WIDTH+2:BYTECNT_WIDTH];

  assign cred_left = (credits_q != '0);

  // Request stays up while words remain and a FIFO slot is reserved
  assign idx_req_o.valid = (words_left_q != '0) & cred_left;
  assign idx_req_o.addr  = word_addr_q;

  assign req_hs = idx_req_o.valid & idx_rsp_i.q_ready;

  // Word address walk, address only moves on a granted request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      words_left_q <= '0;
    end else if (job_start_i) begin
      words_left_q <= span_words;
    end else if (req_hs) begin
      words_left_q <= words_left_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_start_i) begin
      // Mask low bits, fetch whole aligned words only
      word_addr_q <= {cfg_i.idx_addr[ADDR_WIDTH-1:BYTECNT_WIDTH], {BYTECNT_WIDTH{1'b0}}};
    end else if (req_hs) begin
      word_addr_q <= word_addr_q + addr_t'(DATA_WIDTH / 8);
    end
  end

  // Take a credit per request, get one back per FIFO pop
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_q <= CREDIT_WIDTH'(IDX_CREDITS);
    end else begin
      case ({req_hs, credit_give_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  // Responses go straight into the FIFO
  assign push_o      = idx_rsp_i.p_valid;
  assign push_data_o = idx_rsp_i.data;

endmodule

// ==== source/ssr_indir_pkg.sv ====
/*
  Shared definitions for the indirection address stage
  Widths, FIFO and credit depth, job and memory port structs,
  and the union giving byte, halfword and word views of an index word
*/

package ssr_indir_pkg;

  // Datapath widths
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned BYTECNT_WIDTH = 2;
  localparam int unsigned INDEX_WIDTH   = 32;
  localparam int unsigned SHIFT_WIDTH   = 3;
  localparam int unsigned COUNT_WIDTH   = 16;

  // Words buffered or in flight at once
  localparam int unsigned IDX_CREDITS   = 4;
  // Credit counter holds 0 up to IDX_CREDITS
  localparam int unsigned CREDIT_WIDTH  = $clog2(IDX_CREDITS + 1);
  // FIFO slot index width, pointers carry one extra wrap bit
  localparam int unsigned FIFO_AWIDTH   = $clog2(IDX_CREDITS);

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [BYTECNT_WIDTH-1:0] bytecnt_t;
  // 0 is one byte, 1 a halfword, 2 a full word
  typedef logic [1:0]               idx_size_t;
  typedef logic [SHIFT_WIDTH-1:0]   shift_t;
  typedef logic [COUNT_WIDTH-1:0]   count_t;
  typedef logic [INDEX_WIDTH-1:0]   index_t;

  // One fetched word seen as bytes, halfwords or a whole word
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
    data_t            word;
  } idx_word_u;

  // Job description, latched by the top on start
  typedef struct packed {
    addr_t     idx_addr;
    count_t    idx_count;
    idx_size_t size;
    addr_t     data_base;
    shift_t    shift;
  } indir_cfg_t;

  // Read request towards memory
  typedef struct packed {
    addr_t addr;
    logic  valid;
  } idx_req_t;

  // Request grant and in-order read response
  typedef struct packed {
    logic  q_ready;
    logic  p_valid;
    data_t data;
  } idx_rsp_t;

endpackage
